/* list.f */
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/core_sequencer.sv
hdl/pc_counter.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/int_alu.sv
hdl/rv_core_top.sv
bench/tb_clock_gen.sv
bench/rv_core_checker.sv
bench/tb_monitor.sv
bench/tb_core.sv

/* bench/tb_core.sv */
`timescale 1ns/100ps

module tb_core;

    localparam int PROG_LEN    = 48;
    localparam int FIRST_RUN   = 12;
    localparam int WAIT_CYCLES = 40;

    logic        clk_in;
    logic        por_rst;
    logic        mid_rst;
    logic        rst_in;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic        fetch_ack;
    logic [31:0] fetch_data;
    logic        retire;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [4:0]  dbg_sel;
    logic [31:0] dbg_data;
    logic        dbg_check;
    int          error_count;
    int          retire_count;
    integer      seed;
    logic [31:0] prog [0:PROG_LEN-1];

    assign rst_in = por_rst | mid_rst;

    tb_clock_gen u_clock (.clk_in(clk_in), .rst_in(por_rst));

    rv_core_top dut (
        .clk_in(clk_in), .rst_in(rst_in), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack), .fetch_data(fetch_data), .retire(retire), .wb_we(wb_we),
        .wb_rd(wb_rd), .wb_data(wb_data), .dbg_sel(dbg_sel), .dbg_data(dbg_data)
    );

    tb_monitor u_monitor (
        .clk_in(clk_in), .rst_in(rst_in), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ack(fetch_ack), .fetch_data(fetch_data), .retire(retire), .wb_we(wb_we),
        .wb_rd(wb_rd), .wb_data(wb_data), .dbg_sel(dbg_sel), .dbg_data(dbg_data),
        .dbg_check(dbg_check), .error_count(error_count), .retire_count(retire_count)
    );

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    ////////////////////
    // Program builder
    ////////////////////

    task automatic make_instr(output logic [31:0] w);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r  = $random(seed);
        f3 = r[2:0];
        case (r[5:3])
            3'd0, 3'd1, 3'd2: begin
                w = {1'b0, r[6] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, 1'b0, r[11:8],
                     1'b0, r[15:12], f3, 1'b0, r[19:16], rv_isa_pkg::OP};
            end
            3'd3, 3'd4, 3'd5: begin
                imm = r[31:20];
                if (f3 == 3'd1) begin
                    imm = {7'b0, r[24:20]};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, r[6], 5'b0, r[24:20]};
                end
                w = {imm, 1'b0, r[15:12], f3, 1'b0, r[19:16], rv_isa_pkg::OP_IMM};
            end
            3'd6: w = {r[31:12], 1'b0, r[11:8], rv_isa_pkg::LUI};
            default: w = {r[31:7], 7'b0001011};
        endcase
    endtask

    ////////////////////
    // Instruction memory
    ////////////////////

    task automatic serve_fetch();
        int delay;
        int n;
        n = 0;
        while (!fetch_req) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_CYCLES) stop_on_timeout("fetch_req to rise");
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_in);
        if (fetch_addr / rv_isa_pkg::INSTR_BYTES < PROG_LEN) begin
            fetch_data = prog[fetch_addr / rv_isa_pkg::INSTR_BYTES];
        end else begin
            fetch_data = rv_isa_pkg::NOP_INSTR;
        end
        fetch_ack = 1'b1;
        n = 0;
        while (fetch_req) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_CYCLES) stop_on_timeout("fetch_req to fall");
        end
        fetch_ack = 1'b0;
    endtask

    task automatic wait_retire();
        int n;
        n = 0;
        while (!retire) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_CYCLES) stop_on_timeout("retire");
        end
    endtask

    task automatic run_program(input int count);
        for (int i = 0; i < count; i++) begin
            serve_fetch();
            wait_retire();
        end
    endtask

    // Read every register through the debug port
    task automatic sweep_registers();
        for (int r = 0; r < rv_isa_pkg::REG_COUNT; r++) begin
            @(negedge clk_in);
            dbg_sel   = r[4:0];
            dbg_check = 1'b1;
        end
        @(negedge clk_in);
        dbg_check = 1'b0;
    endtask

    initial begin
        int n;
        seed       = 32'h03f2a883;
        mid_rst    = 1'b0;
        fetch_ack  = 1'b0;
        fetch_data = '0;
        dbg_sel    = '0;
        dbg_check  = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            make_instr(prog[i]);
        end
        n = 0;
        while (por_rst !== 1'b0) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_CYCLES) stop_on_timeout("power-on reset release");
        end

        // Partial run, then reset while the core waits for a fetch
        run_program(FIRST_RUN);
        @(negedge clk_in);
        mid_rst = 1'b1;
        repeat (4) @(negedge clk_in);
        mid_rst = 1'b0;
        sweep_registers();

        run_program(PROG_LEN);
        sweep_registers();

        $display("Summary: %0d retirements checked, %0d errors, %0d assertion failures",
                 retire_count, error_count, dut.u_checker.fail_count);
        if (error_count == 0 && dut.u_checker.fail_count == 0
                && retire_count == FIRST_RUN + PROG_LEN) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/tb_monitor.sv */
`timescale 1ns/100ps

module tb_monitor (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic                              fetch_req,
    input  logic [rv_isa_pkg::XLEN-1:0]       fetch_addr,
    input  logic                              fetch_ack,
    input  logic [rv_isa_pkg::XLEN-1:0]       fetch_data,
    input  logic                              retire,
    input  logic                              wb_we,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [rv_isa_pkg::XLEN-1:0]       wb_data,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dbg_sel,
    input  logic [rv_isa_pkg::XLEN-1:0]       dbg_data,
    input  logic                              dbg_check,
    output int                                error_count,
    output int                                retire_count
);

    logic [31:0] shadow [0:rv_isa_pkg::REG_COUNT-1];
    logic [31:0] pending_q [$];
    logic [31:0] expected_pc;
    logic        prev_req;

    // Expected write of one instruction as {we, data}
    function automatic logic [32:0] reference_write(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  sh;
        logic        known;
        a     = shadow[w[19:15]];
        b     = (w[6:0] == rv_isa_pkg::OP) ? shadow[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh    = b[4:0];
        known = (w[6:0] == rv_isa_pkg::OP) || (w[6:0] == rv_isa_pkg::OP_IMM);
        case (w[14:12])
            3'd0: res = (w[6:0] == rv_isa_pkg::OP && w[30]) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: res = w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == rv_isa_pkg::LUI) begin
            res   = {w[31:12], 12'b0};
            known = 1'b1;
        end
        return {known && (w[11:7] != 5'd0), res};
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
        $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
        error_count++;
    endtask

    initial begin
        error_count  = 0;
        retire_count = 0;
    end

    ////////////////////
    // Comparison
    ////////////////////

    always @(posedge clk_in) begin
        logic [31:0] instr;
        logic [32:0] exp_w;
        if (rst_in) begin
            for (int i = 0; i < rv_isa_pkg::REG_COUNT; i++) begin
                shadow[i] = '0;
            end
            pending_q.delete();
            expected_pc = '0;
            prev_req    = 1'b0;
        end else begin
            if (fetch_req && !prev_req && pending_q.size() != 0) begin
                $display("New fetch request rose before the previous instruction retired");
                error_count++;
            end
            if (fetch_req && fetch_ack) begin
                if (fetch_addr !== expected_pc) begin
                    report_value("fetch_addr", expected_pc, fetch_addr);
                end
                if (pending_q.size() != 0) begin
                    $display("Fetch completed while another instruction was in flight");
                    error_count++;
                end
                pending_q.push_back(fetch_data);
                expected_pc = expected_pc + rv_isa_pkg::INSTR_BYTES;
            end
            if (retire) begin
                if (pending_q.size() == 0) begin
                    $display("Retire seen without a completed fetch");
                    error_count++;
                end else begin
                    instr = pending_q.pop_front();
                    exp_w = reference_write(instr);
                    retire_count++;
                    if (wb_we !== exp_w[32]) begin
                        report_value("wb_we", exp_w[32], wb_we);
                    end else if (exp_w[32]) begin
                        if (wb_rd !== instr[11:7]) begin
                            report_value("wb_rd", instr[11:7], wb_rd);
                        end
                        if (wb_data !== exp_w[31:0]) begin
                            report_value("wb_data", exp_w[31:0], wb_data);
                        end
                        shadow[instr[11:7]] = exp_w[31:0];
                    end
                end
            end
            if (dbg_check && dbg_data !== shadow[dbg_sel]) begin
                report_value($sformatf("dbg_data x%0d", dbg_sel), shadow[dbg_sel], dbg_data);
            end
            prev_req = fetch_req;
        end
    end

endmodule

/* bench/rv_core_checker.sv */
`timescale 1ns/100ps

module rv_core_checker (
    input logic clk_in,
    input logic rst_in,
    input logic fetch_req,
    input logic fetch_ack,
    input logic retire
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Request stays up until the ack has been seen
    req_held: assert property (@(posedge clk_in) disable iff (rst_in)
        (fetch_req && !fetch_ack) |=> fetch_req)
        else begin
            $error("fetch_req dropped before fetch_ack was seen");
            fail_count++;
        end

    ack_needs_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(fetch_ack) |-> fetch_req)
        else begin
            $error("fetch_ack rose while fetch_req was low");
            fail_count++;
        end

    retire_single: assert property (@(posedge clk_in) disable iff (rst_in)
        retire |=> !retire)
        else begin
            $error("retire lasted more than one cycle");
            fail_count++;
        end

    // Next request follows the retire cycle directly
    req_after_retire: assert property (@(posedge clk_in) disable iff (rst_in)
        retire |=> fetch_req)
        else begin
            $error("fetch_req not raised in the cycle after retire");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_checker u_checker (
    .clk_in(clk_in), .rst_in(rst_in), .fetch_req(fetch_req),
    .fetch_ack(fetch_ack), .retire(retire)
);

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_in,
    output logic rst_in
);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    // Power-on reset held for 4 cycles, released on a falling edge
    initial begin
        rst_in = 1'b1;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
    end

endmodule

/* hdl/rv_core_top.sv */
`timescale 1ns/100ps

module rv_core_top (
    input  logic                              clk_in,
    input  logic                              rst_in,
    output logic                              fetch_req,
    output logic [rv_isa_pkg::XLEN-1:0]       fetch_addr,
    input  logic                              fetch_ack,
    input  logic [rv_isa_pkg::XLEN-1:0]       fetch_data,
    output logic                              retire,
    output logic                              wb_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0]       wb_data,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dbg_sel,
    output logic [rv_isa_pkg::XLEN-1:0]       dbg_data
);

    logic                              capture_instr;
    logic                              capture_result;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic [rv_isa_pkg::XLEN-1:0]       instr_reg;
    logic [rv_isa_pkg::XLEN-1:0]       result_reg;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    logic                              use_imm;
    core_ctrl_pkg::alu_op_e            alu_op;
    core_ctrl_pkg::wb_src_e            wb_src;
    logic [rv_isa_pkg::XLEN-1:0]       rd1;
    logic [rv_isa_pkg::XLEN-1:0]       rd2;
    logic [rv_isa_pkg::XLEN-1:0]       alu_b;
    logic [rv_isa_pkg::XLEN-1:0]       alu_result;

    ////////////////////
    // Datapath registers
    ////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            instr_reg <= rv_isa_pkg::NOP_INSTR;
        end else if (capture_instr) begin
            instr_reg <= fetch_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (capture_result) begin
            result_reg <= alu_result;
        end
    end

    assign alu_b      = use_imm ? imm : rd2;
    assign fetch_addr = pc;

    // Writes to x0 and unknown opcodes are dropped here
    assign wb_we   = retire && (wb_src == core_ctrl_pkg::ALU) && (rd != '0);
    assign wb_rd   = rd;
    assign wb_data = result_reg;

    ////////////////////
    // Submodules
    ////////////////////

    core_sequencer u_sequencer (
        .clk_in(clk_in), .rst_in(rst_in), .fetch_ack(fetch_ack), .fetch_req(fetch_req),
        .capture_instr(capture_instr), .capture_result(capture_result), .retire(retire)
    );

    pc_counter u_pc (.clk_in(clk_in), .rst_in(rst_in), .advance(retire), .pc(pc));

    instr_decoder u_decoder (
        .instr(instr_reg), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .use_imm(use_imm), .alu_op(alu_op), .wb_src(wb_src)
    );

    reg_file u_regs (
        .clk_in(clk_in), .rst_in(rst_in), .rs1(rs1), .rs2(rs2), .dbg_sel(dbg_sel),
        .rd1(rd1), .rd2(rd2), .dbg_data(dbg_data),
        .wr_en(wb_we), .wr_addr(rd), .wr_data(result_reg)
    );

    int_alu u_alu (.alu_op(alu_op), .a(rd1), .b(alu_b), .result(alu_result));

endmodule

/* hdl/int_alu.sv */
`timescale 1ns/100ps

module int_alu (
    input  core_ctrl_pkg::alu_op_e      alu_op,
    input  logic [rv_isa_pkg::XLEN-1:0] a,
    input  logic [rv_isa_pkg::XLEN-1:0] b,
    output logic [rv_isa_pkg::XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Only the low 5 bits of b count for shifts
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            core_ctrl_pkg::ADD:    result = a + b;
            core_ctrl_pkg::SUB:    result = a - b;
            core_ctrl_pkg::SLL:    result = a << shamt;
            core_ctrl_pkg::SLT:    result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_signed};
            core_ctrl_pkg::SLTU:   result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_unsigned};
            core_ctrl_pkg::XOR:    result = a ^ b;
            core_ctrl_pkg::SRL:    result = a >> shamt;
            core_ctrl_pkg::SRA:    result = $signed(a) >>> shamt;
            core_ctrl_pkg::OR:     result = a | b;
            core_ctrl_pkg::AND:    result = a & b;
            core_ctrl_pkg::PASS_B: result = b;
            default:               result = '0;
        endcase
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                              clk_in,
    input  logic                              rst_in,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] dbg_sel,
    output logic [rv_isa_pkg::XLEN-1:0]       rd1,
    output logic [rv_isa_pkg::XLEN-1:0]       rd2,
    output logic [rv_isa_pkg::XLEN-1:0]       dbg_data,
    input  logic                              wr_en,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]       wr_data
);

    // No storage behind x0
    logic [rv_isa_pkg::XLEN-1:0] regs [1:rv_isa_pkg::REG_COUNT-1];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 1; i < rv_isa_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see the array as it stands, x0 reads zero
    assign rd1      = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2      = (rs2 == '0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_sel == '0) ? '0 : regs[dbg_sel];

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
    input  logic [rv_isa_pkg::XLEN-1:0]       instr,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_isa_pkg::XLEN-1:0]       imm,
    output logic                              use_imm,
    output core_ctrl_pkg::alu_op_e            alu_op,
    output core_ctrl_pkg::wb_src_e            wb_src
);

    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::funct3_e funct3;
    logic                alt;

    // Maps funct3 to an operation, alt picks SUB or SRA where allowed
    function automatic core_ctrl_pkg::alu_op_e arith_op(
        input rv_isa_pkg::funct3_e f3,
        input logic                alt_bit,
        input logic                sub_ok
    );
        case (f3)
            rv_isa_pkg::ADD_SUB: arith_op = (alt_bit && sub_ok) ? core_ctrl_pkg::SUB
                                                                : core_ctrl_pkg::ADD;
            rv_isa_pkg::SLL:     arith_op = core_ctrl_pkg::SLL;
            rv_isa_pkg::SLT:     arith_op = core_ctrl_pkg::SLT;
            rv_isa_pkg::SLTU:    arith_op = core_ctrl_pkg::SLTU;
            rv_isa_pkg::XOR:     arith_op = core_ctrl_pkg::XOR;
            rv_isa_pkg::SRL_SRA: arith_op = alt_bit ? core_ctrl_pkg::SRA
                                                    : core_ctrl_pkg::SRL;
            rv_isa_pkg::OR:      arith_op = core_ctrl_pkg::OR;
            default:             arith_op = core_ctrl_pkg::AND;
        endcase
    endfunction

    ////////////////////
    // Fields
    ////////////////////

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = rv_isa_pkg::funct3_e'(instr[14:12]);
    assign alt    = instr[30];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    ////////////////////
    // Control
    ////////////////////

    always_comb begin
        imm     = {{20{instr[31]}}, instr[31:20]};
        use_imm = 1'b0;
        alu_op  = core_ctrl_pkg::ADD;
        wb_src  = core_ctrl_pkg::NONE;

        case (opcode)
            rv_isa_pkg::OP: begin
                alu_op = arith_op(funct3, alt, 1'b1);
                wb_src = core_ctrl_pkg::ALU;
            end
            rv_isa_pkg::OP_IMM: begin
                // Bit 30 is immediate data here except for SRAI
                alu_op  = arith_op(funct3, alt, 1'b0);
                use_imm = 1'b1;
                wb_src  = core_ctrl_pkg::ALU;
            end
            rv_isa_pkg::LUI: begin
                imm     = {instr[31:12], 12'b0};
                alu_op  = core_ctrl_pkg::PASS_B;
                use_imm = 1'b1;
                wb_src  = core_ctrl_pkg::ALU;
            end
            default: begin
                // Unknown opcode retires as a no-op
                wb_src = core_ctrl_pkg::NONE;
            end
        endcase
    end

endmodule

/* hdl/pc_counter.sv */
`timescale 1ns/100ps

module pc_counter (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         advance,
    output logic [rv_isa_pkg::XLEN-1:0]  pc
);

    localparam logic [rv_isa_pkg::XLEN-1:0] STEP = rv_isa_pkg::INSTR_BYTES;

    // Wraps silently at the top of the address space
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + STEP;
        end
    end

endmodule

/* hdl/core_sequencer.sv */
`timescale 1ns/100ps

module core_sequencer (
    input  logic clk_in,
    input  logic rst_in,
    input  logic fetch_ack,
    output logic fetch_req,
    output logic capture_instr,
    output logic capture_result,
    output logic retire
);

    core_ctrl_pkg::seq_state_e state;

    // Instruction word is taken on the first edge with the ack seen
    assign capture_instr  = (state == core_ctrl_pkg::FETCH_REQ) && fetch_req && fetch_ack;
    assign capture_result = (state == core_ctrl_pkg::EXECUTE);
    assign retire         = (state == core_ctrl_pkg::RETIRE);

    ////////////////////
    // State register
    ////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= core_ctrl_pkg::FETCH_REQ;
            fetch_req <= 1'b0;
        end else begin
            case (state)
                core_ctrl_pkg::FETCH_REQ: begin
                    if (capture_instr) begin
                        // Drop the request on the same edge as the capture
                        fetch_req <= 1'b0;
                        state     <= core_ctrl_pkg::FETCH_RELEASE;
                    end else begin
                        // Raises the request on the first cycle out of reset
                        fetch_req <= 1'b1;
                    end
                end

                core_ctrl_pkg::FETCH_RELEASE: begin
                    // Memory has to let go of the ack first
                    if (!fetch_ack) begin
                        state <= core_ctrl_pkg::EXECUTE;
                    end
                end

                core_ctrl_pkg::EXECUTE: begin
                    state <= core_ctrl_pkg::RETIRE;
                end

                core_ctrl_pkg::RETIRE: begin
                    // Next request goes out right after the retire cycle
                    state     <= core_ctrl_pkg::FETCH_REQ;
                    fetch_req <= 1'b1;
                end

                default: begin
                    state     <= core_ctrl_pkg::FETCH_REQ;
                    fetch_req <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* hdl/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // Sequencer steps for one instruction
    typedef enum logic [2:0] {
        FETCH_REQ     = 3'd0,
        FETCH_RELEASE = 3'd1,
        EXECUTE       = 3'd2,
        RETIRE        = 3'd3
    } seq_state_e;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    // Where the register write comes from
    typedef enum logic {
        NONE = 1'b0,
        ALU  = 1'b1
    } wb_src_e;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    ////////////////////
    // Widths and sizes
    ////////////////////

    // Data and address width
    localparam int XLEN = 32;

    // Register file geometry
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = 5;

    // Byte step from one instruction to the next
    localparam int INSTR_BYTES = 4;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes in bits 6:0
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // Arithmetic funct3 in bits 14:12, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_e;

endpackage
